// ==== logic/ex_settings.svh ====
// execute unit widths
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// data path
`define EX_WORD_W       32                  // one register word
`define EX_DWORD_W      (2 * `EX_WORD_W)    // product and hi/lo pair

// register file addressing
`define EX_REG_ADDR_W   5                   // destination register index

// shift amount taken from src1 low bits
`define EX_SHAMT_W      5

// encoded fields
`define EX_OP_W         6                   // opcode enum
`define EX_GRP_W        3                   // result group enum

`endif

// ==== logic/ex_pkg.sv ====
// execute unit types
`include "ex_settings.svh"

package ex_pkg;

    typedef logic [`EX_WORD_W-1:0]     word_t;
    typedef logic [`EX_DWORD_W-1:0]    dword_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    // operations handled by the unit, immediates already resolved upstream
    typedef enum logic [`EX_OP_W-1:0] {
        OP_NOP   = 6'h00,
        OP_OR    = 6'h01,
        OP_AND   = 6'h02,
        OP_NOR   = 6'h03,
        OP_XOR   = 6'h04,
        OP_SLL   = 6'h05,
        OP_SRL   = 6'h06,
        OP_SRA   = 6'h07,
        OP_ADD   = 6'h08,
        OP_ADDU  = 6'h09,
        OP_SUB   = 6'h0a,
        OP_SUBU  = 6'h0b,
        OP_SLT   = 6'h0c,
        OP_SLTU  = 6'h0d,
        OP_CLZ   = 6'h0e,
        OP_CLO   = 6'h0f,
        OP_MUL   = 6'h10,
        OP_MULT  = 6'h11,
        OP_MULTU = 6'h12,
        OP_MFHI  = 6'h13,
        OP_MFLO  = 6'h14,
        OP_MTHI  = 6'h15,
        OP_MTLO  = 6'h16,
        OP_TEQ   = 6'h17,
        OP_TNE   = 6'h18,
        OP_TGE   = 6'h19,
        OP_TGEU  = 6'h1a,
        OP_TLT   = 6'h1b,
        OP_TLTU  = 6'h1c
    } alu_op_e;

    typedef enum logic [`EX_GRP_W-1:0] {
        GRP_NONE    = 3'd0,   // no register result
        GRP_LOGIC   = 3'd1,
        GRP_SHIFT   = 3'd2,
        GRP_ARITH   = 3'd3,   // add, sub, compare, count
        GRP_MUL_LOW = 3'd4,
        GRP_MOVE    = 3'd5    // mfhi / mflo
    } res_group_e;

    typedef struct packed {
        logic       valid;
        alu_op_e    op;
        res_group_e group;
        word_t      src1;
        word_t      src2;
        word_t      src2_add;   // adder operand, negated for subtract
        logic       sub_cmp;    // subtract or signed compare
        reg_addr_t  wd;
        logic       wreg;
    } issue_t;

    typedef struct packed {
        logic  we;
        word_t hi;
        word_t lo;
    } hilo_wr_t;

    typedef struct packed {
        logic       valid;
        res_group_e group;
        word_t      result;     // candidate word
        reg_addr_t  wd;
        logic       wreg;
        logic       ov;
        logic       trap;
        hilo_wr_t   hilo;
    } compute_t;

    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
        logic      ov_exc;
        logic      trap_exc;
    } wb_result_t;

endpackage

// ==== logic/ex_issue.sv ====
// execute issue stage
`timescale 1ns/1ps

module ex_issue (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  ex_pkg::alu_op_e   op_i,
    input  ex_pkg::word_t     src1_i,
    input  ex_pkg::word_t     src2_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    output ex_pkg::issue_t    issue_o
);

    ex_pkg::res_group_e group;
    logic               sub_cmp;
    ex_pkg::issue_t     issue_d;
    ex_pkg::issue_t     payload_q;
    logic               valid_q;
    logic               wreg_q;

    always_comb begin
        case (op_i)
            ex_pkg::OP_OR, ex_pkg::OP_AND,
            ex_pkg::OP_NOR, ex_pkg::OP_XOR: group = ex_pkg::GRP_LOGIC;
            ex_pkg::OP_SLL, ex_pkg::OP_SRL,
            ex_pkg::OP_SRA: group = ex_pkg::GRP_SHIFT;
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU,
            ex_pkg::OP_SLT, ex_pkg::OP_SLTU,
            ex_pkg::OP_CLZ, ex_pkg::OP_CLO: group = ex_pkg::GRP_ARITH;
            ex_pkg::OP_MUL: group = ex_pkg::GRP_MUL_LOW;
            ex_pkg::OP_MFHI, ex_pkg::OP_MFLO: group = ex_pkg::GRP_MOVE;
            default: group = ex_pkg::GRP_NONE; // traps, hi/lo writes, nop
        endcase
    end

    // signed traps share the subtract path for their compare
    assign sub_cmp = op_i inside {ex_pkg::OP_SUB, ex_pkg::OP_SUBU, ex_pkg::OP_SLT,
                                  ex_pkg::OP_TGE, ex_pkg::OP_TLT};

    always_comb begin
        issue_d          = '0;
        issue_d.valid    = valid_i;
        issue_d.op       = op_i;
        issue_d.group    = group;
        issue_d.src1     = src1_i;
        issue_d.src2     = src2_i;
        issue_d.src2_add = sub_cmp ? (~src2_i + ex_pkg::word_t'(1)) : src2_i; // two's complement
        issue_d.sub_cmp  = sub_cmp;
        issue_d.wd       = wd_i;
        issue_d.wreg     = wreg_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            wreg_q  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            wreg_q  <= valid_i & wreg_i; // no write from a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            payload_q <= issue_d;
        end
    end

    always_comb begin
        issue_o       = payload_q;
        issue_o.valid = valid_q;
        issue_o.wreg  = wreg_q;
    end

endmodule

// ==== logic/ex_alu.sv ====
// execute compute stage
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_alu (
    input  logic             clk,
    input  logic             rst_n_i,
    input  ex_pkg::issue_t   issue_i,
    input  ex_pkg::word_t    hi_i,
    input  ex_pkg::word_t    lo_i,
    output ex_pkg::word_t    mult_a_o,
    output ex_pkg::word_t    mult_b_o,
    output logic             mult_signed_o,
    input  ex_pkg::dword_t   product_i,
    output ex_pkg::compute_t compute_o
);

    localparam int MSB   = `EX_WORD_W - 1;
    localparam int CNT_W = $clog2(`EX_WORD_W) + 1;

    ex_pkg::word_t    src1;
    ex_pkg::word_t    src2;
    ex_pkg::word_t    sum;
    ex_pkg::word_t    logic_res;
    ex_pkg::word_t    shift_res;
    ex_pkg::word_t    arith_res;
    ex_pkg::word_t    move_res;
    logic [CNT_W-1:0] count;
    logic             ov_cond;
    logic             lt;
    logic             trap_cond;
    ex_pkg::hilo_wr_t hilo_d;
    ex_pkg::compute_t compute_d;
    ex_pkg::compute_t payload_q;
    logic             valid_q;
    logic             wreg_q;
    logic             ov_q;
    logic             trap_q;
    logic             hilo_we_q;

    function automatic logic [CNT_W-1:0] lead_zeros(input ex_pkg::word_t w);
        logic [CNT_W-1:0] n;
        logic             hit;
        n   = '0;
        hit = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (w[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign src1 = issue_i.src1;
    assign src2 = issue_i.src2;
    assign sum  = src1 + issue_i.src2_add; // src1 - src2 when negated

    // same effective operand signs and a flipped sum sign
    assign ov_cond = (issue_i.op inside {ex_pkg::OP_ADD, ex_pkg::OP_SUB}) &
                     ~(src1[MSB] ^ src2[MSB] ^ issue_i.sub_cmp) &
                     (sum[MSB] ^ src1[MSB]);

    // signed: neg vs pos, or same sign and negative difference
    assign lt = issue_i.sub_cmp ? ((src1[MSB] & ~src2[MSB]) |
                                   (~src1[MSB] & ~src2[MSB] & sum[MSB]) |
                                   (src1[MSB] & src2[MSB] & sum[MSB]))
                                : (src1 < src2);

    assign count = (issue_i.op == ex_pkg::OP_CLO) ? lead_zeros(~src1) : lead_zeros(src1);

    assign mult_a_o      = src1;
    assign mult_b_o      = src2;
    assign mult_signed_o = issue_i.op inside {ex_pkg::OP_MUL, ex_pkg::OP_MULT};

    always_comb begin
        logic_res = '0;
        shift_res = '0;
        arith_res = '0;
        move_res  = '0;
        trap_cond = 1'b0;
        hilo_d    = '0;
        case (issue_i.op)
            ex_pkg::OP_OR:   logic_res = src1 | src2;
            ex_pkg::OP_AND:  logic_res = src1 & src2;
            ex_pkg::OP_NOR:  logic_res = ~(src1 | src2);
            ex_pkg::OP_XOR:  logic_res = src1 ^ src2;
            ex_pkg::OP_SLL:  shift_res = src2 << src1[`EX_SHAMT_W-1:0];
            ex_pkg::OP_SRL:  shift_res = src2 >> src1[`EX_SHAMT_W-1:0];
            ex_pkg::OP_SRA:  shift_res = $signed(src2) >>> src1[`EX_SHAMT_W-1:0];
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU,
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU: arith_res = sum;
            ex_pkg::OP_SLT, ex_pkg::OP_SLTU: arith_res = ex_pkg::word_t'(lt);
            ex_pkg::OP_CLZ, ex_pkg::OP_CLO:  arith_res = ex_pkg::word_t'(count);
            ex_pkg::OP_MFHI: move_res = hi_i; // forwarded value
            ex_pkg::OP_MFLO: move_res = lo_i;
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU: begin
                hilo_d.we = 1'b1;
                hilo_d.hi = product_i[`EX_DWORD_W-1:`EX_WORD_W];
                hilo_d.lo = product_i[`EX_WORD_W-1:0];
            end
            ex_pkg::OP_MTHI: begin
                hilo_d.we = 1'b1;
                hilo_d.hi = src1;
                hilo_d.lo = lo_i; // lo unchanged
            end
            ex_pkg::OP_MTLO: begin
                hilo_d.we = 1'b1;
                hilo_d.hi = hi_i;
                hilo_d.lo = src1;
            end
            ex_pkg::OP_TEQ:  trap_cond = (src1 == src2);
            ex_pkg::OP_TNE:  trap_cond = (src1 != src2);
            ex_pkg::OP_TGE, ex_pkg::OP_TGEU: trap_cond = ~lt;
            ex_pkg::OP_TLT, ex_pkg::OP_TLTU: trap_cond = lt;
            default: ;
        endcase
    end

    always_comb begin
        compute_d       = '0;
        compute_d.valid = issue_i.valid;
        compute_d.group = issue_i.group;
        compute_d.wd    = issue_i.wd;
        compute_d.wreg  = issue_i.wreg;
        compute_d.ov    = ov_cond;
        compute_d.trap  = trap_cond;
        compute_d.hilo  = hilo_d;
        case (issue_i.group)
            ex_pkg::GRP_LOGIC:   compute_d.result = logic_res;
            ex_pkg::GRP_SHIFT:   compute_d.result = shift_res;
            ex_pkg::GRP_ARITH:   compute_d.result = arith_res;
            ex_pkg::GRP_MUL_LOW: compute_d.result = product_i[`EX_WORD_W-1:0];
            ex_pkg::GRP_MOVE:    compute_d.result = move_res;
            default:             compute_d.result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            wreg_q    <= 1'b0;
            ov_q      <= 1'b0;
            trap_q    <= 1'b0;
            hilo_we_q <= 1'b0;
        end else begin
            valid_q   <= issue_i.valid;
            wreg_q    <= issue_i.wreg;
            ov_q      <= issue_i.valid & ov_cond;
            trap_q    <= issue_i.valid & trap_cond;
            hilo_we_q <= issue_i.valid & hilo_d.we; // bubbles never touch hi/lo
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i.valid) begin
            payload_q <= compute_d;
        end
    end

    always_comb begin
        compute_o         = payload_q;
        compute_o.valid   = valid_q;
        compute_o.wreg    = wreg_q;
        compute_o.ov      = ov_q;
        compute_o.trap    = trap_q;
        compute_o.hilo.we = hilo_we_q;
    end

endmodule

// ==== logic/ex_mult.sv ====
// signed and unsigned multiplier
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_mult (
    input  ex_pkg::word_t  a_i,
    input  ex_pkg::word_t  b_i,
    input  logic           signed_i,
    output ex_pkg::dword_t product_o
);

    localparam int MSB = `EX_WORD_W - 1;

    ex_pkg::word_t  mag_a;
    ex_pkg::word_t  mag_b;
    ex_pkg::dword_t mag_prod;
    logic           negate;

    // magnitudes only when the operands are signed
    assign mag_a = (signed_i && a_i[MSB]) ? (~a_i + ex_pkg::word_t'(1)) : a_i;
    assign mag_b = (signed_i && b_i[MSB]) ? (~b_i + ex_pkg::word_t'(1)) : b_i;

    assign mag_prod = ex_pkg::dword_t'(mag_a) * ex_pkg::dword_t'(mag_b);

    assign negate = signed_i & (a_i[MSB] ^ b_i[MSB]); // signs differ

    assign product_o = negate ? (~mag_prod + ex_pkg::dword_t'(1)) : mag_prod;

endmodule

// ==== logic/hilo_unit.sv ====
// hi/lo register pair
`timescale 1ns/1ps

module hilo_unit (
    input  logic             clk,
    input  logic             rst_n_i,
    input  ex_pkg::hilo_wr_t pending_i,
    output ex_pkg::word_t    hi_o,
    output ex_pkg::word_t    lo_o,
    output ex_pkg::word_t    hi_reg_o,
    output ex_pkg::word_t    lo_reg_o
);

    ex_pkg::word_t hi_q;
    ex_pkg::word_t lo_q;

    // commit the write held in the compute register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (pending_i.we) begin
            hi_q <= pending_i.hi;
            lo_q <= pending_i.lo;
        end
    end

    // the younger instruction sees the older pending write first
    assign hi_o = pending_i.we ? pending_i.hi : hi_q;
    assign lo_o = pending_i.we ? pending_i.lo : lo_q;

    assign hi_reg_o = hi_q;
    assign lo_reg_o = lo_q;

endmodule

// ==== logic/ex_writeback.sv ====
// execute writeback stage
`timescale 1ns/1ps

module ex_writeback (
    input  logic               clk,
    input  logic               rst_n_i,
    input  ex_pkg::compute_t   compute_i,
    output logic               wb_valid_o,
    output ex_pkg::wb_result_t wb_o
);

    ex_pkg::word_t     wdata_d;
    ex_pkg::word_t     wdata_q;
    ex_pkg::reg_addr_t wd_q;
    logic              valid_q;
    logic              wreg_q;
    logic              ov_q;
    logic              trap_q;

    // traps and hi/lo-only ops carry no register data
    assign wdata_d = (compute_i.group == ex_pkg::GRP_NONE) ? '0 : compute_i.result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            wreg_q  <= 1'b0;
            ov_q    <= 1'b0;
            trap_q  <= 1'b0;
        end else begin
            valid_q <= compute_i.valid;
            wreg_q  <= compute_i.wreg & ~compute_i.ov; // overflow drops the write
            ov_q    <= compute_i.ov;
            trap_q  <= compute_i.trap;
        end
    end

    always_ff @(posedge clk) begin
        if (compute_i.valid) begin
            wd_q    <= compute_i.wd;
            wdata_q <= wdata_d;
        end
    end

    assign wb_valid_o = valid_q;

    always_comb begin
        wb_o.wd       = wd_q;
        wb_o.wreg     = wreg_q;
        wb_o.wdata    = wdata_q;
        wb_o.ov_exc   = ov_q;
        wb_o.trap_exc = trap_q;
    end

endmodule

// ==== logic/ex_top.sv ====
// integer execute unit top
`timescale 1ns/1ps

module ex_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               valid_i,
    input  ex_pkg::alu_op_e    op_i,
    input  ex_pkg::word_t      src1_i,
    input  ex_pkg::word_t      src2_i,
    input  ex_pkg::reg_addr_t  wd_i,
    input  logic               wreg_i,
    output logic               wb_valid_o,
    output ex_pkg::wb_result_t wb_o,
    output ex_pkg::word_t      hi_o,
    output ex_pkg::word_t      lo_o
);

    ex_pkg::issue_t   issue;
    ex_pkg::compute_t compute;
    ex_pkg::word_t    hi_fwd;      // pending write ahead of committed
    ex_pkg::word_t    lo_fwd;
    ex_pkg::word_t    mult_a;
    ex_pkg::word_t    mult_b;
    logic             mult_signed;
    ex_pkg::dword_t   product;

    ex_issue u_issue (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .wd_i    (wd_i),
        .wreg_i  (wreg_i),
        .issue_o (issue)
    );

    ex_alu u_alu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_i       (issue),
        .hi_i          (hi_fwd),
        .lo_i          (lo_fwd),
        .mult_a_o      (mult_a),
        .mult_b_o      (mult_b),
        .mult_signed_o (mult_signed),
        .product_i     (product),
        .compute_o     (compute)
    );

    ex_mult u_mult (
        .a_i       (mult_a),
        .b_i       (mult_b),
        .signed_i  (mult_signed),
        .product_o (product)
    );

    hilo_unit u_hilo (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pending_i (compute.hilo),
        .hi_o      (hi_fwd),
        .lo_o      (lo_fwd),
        .hi_reg_o  (hi_o),
        .lo_reg_o  (lo_o)
    );

    ex_writeback u_writeback (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .compute_i  (compute),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

endmodule

// ==== test/tb_ex_vectors.svh ====
// directed execute vectors
`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

// line 1: name, op, src1, src2, wd, wreg in
// line 2: expected wdata, wreg, ov_exc, trap_exc, hi, lo after commit
task automatic load_directed();
    add_vec("or", ex_pkg::OP_OR, 32'h0f0f_00ff, 32'h00ff_0f0f, 5'd1, 1'b1,
            32'h0fff_0fff, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("and", ex_pkg::OP_AND, 32'h0f0f_00ff, 32'h00ff_0f0f, 5'd2, 1'b1,
            32'h000f_000f, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("nor", ex_pkg::OP_NOR, 32'h0f0f_00ff, 32'h00ff_0f0f, 5'd3, 1'b1,
            32'hf000_f000, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("xor", ex_pkg::OP_XOR, 32'h0f0f_00ff, 32'h00ff_0f0f, 5'd4, 1'b1,
            32'h0ff0_0ff0, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("sll", ex_pkg::OP_SLL, 32'h0000_0004, 32'h8000_0011, 5'd5, 1'b1,
            32'h0000_0110, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("srl", ex_pkg::OP_SRL, 32'h0000_0004, 32'h8000_0010, 5'd6, 1'b1,
            32'h0800_0001, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("sra_neg", ex_pkg::OP_SRA, 32'h0000_0004, 32'h8000_0010, 5'd7, 1'b1,
            32'hf800_0001, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("add_ov", ex_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd8, 1'b1,
            32'h8000_0000, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0);
    add_vec("addu_wrap", ex_pkg::OP_ADDU, 32'h7fff_ffff, 32'h0000_0001, 5'd9, 1'b1,
            32'h8000_0000, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("sub", ex_pkg::OP_SUB, 32'hffff_fffe, 32'h0000_0003, 5'd10, 1'b1,
            32'hffff_fffb, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("sub_ov_min", ex_pkg::OP_SUB, 32'h0000_0000, 32'h8000_0000, 5'd10, 1'b1,
            32'h8000_0000, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0);
    add_vec("slt_mixed", ex_pkg::OP_SLT, 32'hffff_ffff, 32'h0000_0001, 5'd11, 1'b1,
            32'h0000_0001, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("sltu_mixed", ex_pkg::OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 5'd12, 1'b1,
            32'h0000_0000, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("clz_zero", ex_pkg::OP_CLZ, 32'h0000_0000, 32'h0000_0000, 5'd13, 1'b1,
            32'h0000_0020, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("clo_ones", ex_pkg::OP_CLO, 32'hffff_ffff, 32'h0000_0000, 5'd14, 1'b1,
            32'h0000_0020, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
    add_vec("mult_neg", ex_pkg::OP_MULT, 32'hffff_fffe, 32'h0000_0003, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'hffff_ffff, 32'hffff_fffa);
    add_vec("multu", ex_pkg::OP_MULTU, 32'hffff_fffe, 32'h0000_0003, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'h0000_0002, 32'hffff_fffa);
    add_vec("mul_low", ex_pkg::OP_MUL, 32'hffff_fffe, 32'h0000_0003, 5'd15, 1'b1,
            32'hffff_fffa, 1'b1, 1'b0, 1'b0, 32'h0000_0002, 32'hffff_fffa);
    add_vec("mthi", ex_pkg::OP_MTHI, 32'h1234_5678, 32'h0, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'hffff_fffa);
    add_vec("mfhi_fwd", ex_pkg::OP_MFHI, 32'h0, 32'h0, 5'd16, 1'b1,
            32'h1234_5678, 1'b1, 1'b0, 1'b0, 32'h1234_5678, 32'hffff_fffa);
    add_vec("mtlo", ex_pkg::OP_MTLO, 32'h9abc_def0, 32'h0, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'h9abc_def0);
    add_vec("mflo_fwd", ex_pkg::OP_MFLO, 32'h0, 32'h0, 5'd17, 1'b1,
            32'h9abc_def0, 1'b1, 1'b0, 1'b0, 32'h1234_5678, 32'h9abc_def0);
    add_vec("teq", ex_pkg::OP_TEQ, 32'h0000_0005, 32'h0000_0005, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b1, 32'h1234_5678, 32'h9abc_def0);
    add_vec("tne", ex_pkg::OP_TNE, 32'h0000_0005, 32'h0000_0005, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'h9abc_def0);
    add_vec("teq_ne", ex_pkg::OP_TEQ, 32'h0000_0005, 32'h0000_0006, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'h9abc_def0);
    add_vec("tne_ne", ex_pkg::OP_TNE, 32'h0000_0005, 32'h0000_0006, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b1, 32'h1234_5678, 32'h9abc_def0);
    add_vec("tge_mixed", ex_pkg::OP_TGE, 32'hffff_ffff, 32'h0000_0001, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'h9abc_def0);
    add_vec("tgeu_mixed", ex_pkg::OP_TGEU, 32'hffff_ffff, 32'h0000_0001, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b1, 32'h1234_5678, 32'h9abc_def0);
    add_vec("tlt_mixed", ex_pkg::OP_TLT, 32'hffff_ffff, 32'h0000_0001, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b1, 32'h1234_5678, 32'h9abc_def0);
    add_vec("tltu_mixed", ex_pkg::OP_TLTU, 32'hffff_ffff, 32'h0000_0001, 5'd0, 1'b0,
            32'h0, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'h9abc_def0);
endtask

`endif

// ==== test/tb_ex_top.sv ====
// execute unit testbench
`timescale 1ns/1ps

module tb_ex_top;

    localparam int CLK_PERIOD = 20;
    localparam int RAND_COUNT = 64;

    typedef struct packed {
        ex_pkg::alu_op_e   op;
        ex_pkg::word_t     src1;
        ex_pkg::word_t     src2;
        ex_pkg::reg_addr_t wd;
        logic              wreg_in;
        ex_pkg::word_t     wdata;
        logic              wreg;
        logic              ov;
        logic              trap;
        ex_pkg::word_t     hi;    // committed state after this entry
        ex_pkg::word_t     lo;
    } vec_t;

    logic               clk;
    logic               rst_n_i;
    logic               valid_i;
    ex_pkg::alu_op_e    op_i;
    ex_pkg::word_t      src1_i;
    ex_pkg::word_t      src2_i;
    ex_pkg::reg_addr_t  wd_i;
    logic               wreg_i;
    logic               wb_valid_o;
    ex_pkg::wb_result_t wb_o;
    ex_pkg::word_t      hi_o;
    ex_pkg::word_t      lo_o;

    vec_t          table_q[$];
    string         name_q[$];
    vec_t          exp_q[$];     // in flight, oldest first
    string         exp_name_q[$];
    int            total_entries = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            other_errors = 0;
    logic [31:0]   lfsr_state;

    ex_top u_ex_top (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .src1_i     (src1_i),
        .src2_i     (src2_i),
        .wd_i       (wd_i),
        .wreg_i     (wreg_i),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o)
    );

    task automatic add_vec(input string name, input ex_pkg::alu_op_e op,
                           input ex_pkg::word_t src1, input ex_pkg::word_t src2,
                           input ex_pkg::reg_addr_t wd, input logic wreg_in,
                           input ex_pkg::word_t wdata, input logic wreg, input logic ov,
                           input logic trap, input ex_pkg::word_t hi, input ex_pkg::word_t lo);
        vec_t v;
        v = '{op, src1, src2, wd, wreg_in, wdata, wreg, ov, trap, hi, lo};
        table_q.push_back(v);
        name_q.push_back(name);
    endtask

    `include "tb_ex_vectors.svh"

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output ex_pkg::word_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]}; // one step per bit
        end
    endtask

    task automatic add_random(input int count);
        ex_pkg::word_t a;
        ex_pkg::word_t b;
        ex_pkg::word_t sel;
        vec_t          last;
        last = table_q[table_q.size() - 1];
        for (int i = 0; i < count; i++) begin
            take_bits(2, sel);
            take_bits(32, a);
            take_bits(32, b);
            case (sel % 3)
                0: add_vec($sformatf("rand_addu_%0d", i), ex_pkg::OP_ADDU, a, b, 5'd20, 1'b1,
                           a + b, 1'b1, 1'b0, 1'b0, last.hi, last.lo);
                1: add_vec($sformatf("rand_xor_%0d", i), ex_pkg::OP_XOR, a, b, 5'd21, 1'b1,
                           a ^ b, 1'b1, 1'b0, 1'b0, last.hi, last.lo);
                default: add_vec($sformatf("rand_sltu_%0d", i), ex_pkg::OP_SLTU, a, b, 5'd22,
                                 1'b1, ex_pkg::word_t'(a < b), 1'b1, 1'b0, 1'b0,
                                 last.hi, last.lo);
            endcase
        end
    endtask

    task automatic check_word(input string test, input string field, input ex_pkg::word_t exp,
                              input ex_pkg::word_t act, inout bit ok);
        assert (act === exp) else begin
            $display("FAILED %s %s expected %h actual %h", test, field, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %-16s %s", name, ok ? "ok" : "mismatch");
    endtask

    task automatic check_result();
        vec_t  e;
        string name;
        bit    ok;
        if (exp_q.size() == 0) begin
            $display("a result came out with no operation in flight");
            other_errors++;
        end else begin
            e    = exp_q.pop_front();
            name = exp_name_q.pop_front();
            ok   = 1'b1;
            check_word(name, "wd", ex_pkg::word_t'(e.wd), ex_pkg::word_t'(wb_o.wd), ok);
            check_word(name, "wreg", ex_pkg::word_t'(e.wreg), ex_pkg::word_t'(wb_o.wreg), ok);
            check_word(name, "wdata", e.wdata, wb_o.wdata, ok);
            check_word(name, "ov_exc", ex_pkg::word_t'(e.ov), ex_pkg::word_t'(wb_o.ov_exc), ok);
            check_word(name, "trap_exc", ex_pkg::word_t'(e.trap),
                       ex_pkg::word_t'(wb_o.trap_exc), ok);
            check_word(name, "hi", e.hi, hi_o, ok); // committed on the result edge
            check_word(name, "lo", e.lo, lo_o, ok);
            report_test(name, ok);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // outputs only move on the rising edge
    always @(negedge clk) begin
        if (rst_n_i && wb_valid_o) begin
            check_result();
        end
    end

    initial begin
        wait (total_entries != 0);
        #((total_entries + 40) * CLK_PERIOD);
        $display("timeout: results still missing after %0d entries", total_entries);
        $display("Verification failed");
        $finish;
    end

    initial begin
        bit ok;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        op_i       = ex_pkg::OP_NOP;
        src1_i     = '0;
        src2_i     = '0;
        wd_i       = '0;
        wreg_i     = 1'b0;
        lfsr_state = 32'd84778;
        load_directed();
        add_random(RAND_COUNT);
        total_entries = table_q.size();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        ok = 1'b1;
        check_word("reset_state", "wb_valid", '0, ex_pkg::word_t'(wb_valid_o), ok);
        check_word("reset_state", "hi", '0, hi_o, ok);
        check_word("reset_state", "lo", '0, lo_o, ok);
        report_test("reset_state", ok);
        foreach (table_q[i]) begin
            @(negedge clk);
            valid_i = 1'b1;  // back to back, one per cycle
            op_i    = table_q[i].op;
            src1_i  = table_q[i].src1;
            src2_i  = table_q[i].src2;
            wd_i    = table_q[i].wd;
            wreg_i  = table_q[i].wreg_in;
            exp_q.push_back(table_q[i]);
            exp_name_q.push_back(name_q[i]);
        end
        @(negedge clk);
        valid_i = 1'b0;
        op_i    = ex_pkg::OP_NOP;
        wreg_i  = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (tests_run != total_entries + 1) begin
            $display("only %0d of %0d tests completed", tests_run, total_entries + 1);
            other_errors++;
        end
        $display("tests: %0d run, %0d failed, %0d other errors",
                 tests_run, tests_failed, other_errors);
        if (tests_failed == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
+incdir+test
logic/ex_pkg.sv
logic/ex_issue.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/hilo_unit.sv
logic/ex_writeback.sv
logic/ex_top.sv
test/tb_ex_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_ex_top \
    -o sim_ex_top

./obj_dir/sim_ex_top | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
